//--- design/dualIssuePkg.sv
`default_nettype none

package dualIssuePkg;

    localparam int xLen = 32;
    localparam int regCount = 32;

    typedef logic [xLen-1:0] word_t;
    typedef logic [$clog2(regCount)-1:0] regIndex_t;

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        opReg = 7'b0110011,
        opImm = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu
    } aluOp_e;

    typedef struct packed {
        word_t slotA; // older in program order
        word_t slotB;
    } packet_t;

    typedef struct packed {
        logic      writes;
        regIndex_t rd;
        regIndex_t rs1;
        regIndex_t rs2;
        logic      usesImm;
        word_t     imm;
        aluOp_e    op;
    } slotOp_t;

    typedef struct packed {
        slotOp_t slot;
        word_t   src1Value;
        word_t   src2Value;
        logic    valid;
    } issued_t;

    // one register write leaving the pipeline
    typedef struct packed {
        logic      valid;
        regIndex_t rd;
        word_t     value;
    } retire_t;

endpackage

`default_nettype wire

//--- design/packetIntake.sv
`timescale 1ns/1ps
`default_nettype none

module packetIntake (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  packetReq,
    input  dualIssuePkg::packet_t packet,
    output logic                  packetAck,
    output dualIssuePkg::packet_t held,
    output logic                  heldValid,
    input  logic                  take
);
    import dualIssuePkg::*;

    typedef enum logic [1:0] {
        idle,
        acked,
        waitLow
    } intakeState_e;

    intakeState_e state;
    logic capture;

    assign capture = (state == idle) && packetReq && !heldValid;
    assign packetAck = (state != idle);

    // four-phase handshake
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (capture) state <= acked;
                acked:   state <= packetReq ? waitLow : idle;
                waitLow: if (!packetReq) state <= idle; // sender has dropped req
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            heldValid <= 1'b0;
        end else if (capture) begin
            heldValid <= 1'b1;
        end else if (take) begin
            heldValid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (capture) held <= packet;
    end

    // sender keeps req up until it has seen the ack
    reqHeldUntilAck: assert property (
        @(posedge clock) disable iff (reset) $fell(packetReq) |-> packetAck
    );

endmodule

`default_nettype wire

//--- design/slotDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module slotDecoder (
    input  dualIssuePkg::word_t   instruction,
    output dualIssuePkg::slotOp_t slot
);
    import dualIssuePkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic isReg;
    logic isImm;
    logic legal;

    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign isReg = (opcode_e'(instruction[6:0]) == opReg);
    assign isImm = (opcode_e'(instruction[6:0]) == opImm);

    always_comb begin
        slot.rd = instruction[11:7];
        slot.rs1 = instruction[19:15];
        slot.rs2 = instruction[24:20];
        slot.imm = {{20{instruction[31]}}, instruction[31:20]}; // I immediate
        slot.usesImm = isImm;

        case (funct3)
            3'b000:  slot.op = (isReg && funct7[5]) ? aluSub : aluAdd;
            3'b001:  slot.op = aluSll;
            3'b010:  slot.op = aluSlt;
            3'b011:  slot.op = aluSltu;
            3'b100:  slot.op = aluXor;
            3'b101:  slot.op = funct7[5] ? aluSra : aluSrl;
            3'b110:  slot.op = aluOr;
            default: slot.op = aluAnd;
        endcase

        // funct7 only matters for R-type and the immediate shifts
        if (isReg) begin
            legal = (funct7 == 7'h00)
                || ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        end else if (isImm) begin
            if (funct3 == 3'b001) legal = (funct7 == 7'h00);
            else if (funct3 == 3'b101) legal = (funct7 == 7'h00) || (funct7 == 7'h20);
            else legal = 1'b1;
        end else begin
            legal = 1'b0;
        end

        slot.writes = legal && (slot.rd != '0); // x0 writes are dropped here
    end

endmodule

`default_nettype wire

//--- design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                    clock,
    input  logic                    reset,
    input  dualIssuePkg::regIndex_t rs1A,
    input  dualIssuePkg::regIndex_t rs2A,
    input  dualIssuePkg::regIndex_t rs1B,
    input  dualIssuePkg::regIndex_t rs2B,
    output dualIssuePkg::word_t     value1A,
    output dualIssuePkg::word_t     value2A,
    output dualIssuePkg::word_t     value1B,
    output dualIssuePkg::word_t     value2B,
    input  dualIssuePkg::retire_t   writeA,
    input  dualIssuePkg::retire_t   writeB
);
    import dualIssuePkg::*;

    word_t regs [1:regCount-1]; // x0 is not stored

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (writeA.valid && (writeA.rd != '0)) regs[writeA.rd] <= writeA.value;
            if (writeB.valid && (writeB.rd != '0)) regs[writeB.rd] <= writeB.value; // B wins
        end
    end

    // write-through, younger slot first
    function automatic word_t readPort(regIndex_t index);
        word_t value;
        if (index == '0) value = '0;
        else if (writeB.valid && (writeB.rd == index)) value = writeB.value;
        else if (writeA.valid && (writeA.rd == index)) value = writeA.value;
        else value = regs[index];
        return value;
    endfunction

    always_comb begin
        value1A = readPort(rs1A);
        value2A = readPort(rs2A);
        value1B = readPort(rs1B);
        value2B = readPort(rs2B);
    end

endmodule

`default_nettype wire

//--- design/issueStage.sv
`timescale 1ns/1ps
`default_nettype none

module issueStage (
    input  logic                  clock,
    input  logic                  reset,
    input  dualIssuePkg::packet_t held,
    input  logic                  heldValid,
    output logic                  take,
    input  dualIssuePkg::retire_t writeA,
    input  dualIssuePkg::retire_t writeB,
    output dualIssuePkg::issued_t issuedA,
    output dualIssuePkg::issued_t issuedB
);
    import dualIssuePkg::*;

    slotOp_t decA, decB;
    word_t value1A, value2A, value1B, value2B;
    logic aDone; // slot A already sent, B still waiting
    logic hazard;
    logic issueA, issueB;

    // younger slot touches a register the older one writes
    function automatic logic conflicts(slotOp_t older, slotOp_t younger);
        return older.writes
            && ((older.rd == younger.rs1)
            || (!younger.usesImm && (older.rd == younger.rs2))
            || (younger.writes && (older.rd == younger.rd)));
    endfunction

    slotDecoder decoderA (.instruction(held.slotA), .slot(decA));
    slotDecoder decoderB (.instruction(held.slotB), .slot(decB));

    registerFile regs (
        .clock(clock),
        .reset(reset),
        .rs1A(decA.rs1),
        .rs2A(decA.rs2),
        .rs1B(decB.rs1),
        .rs2B(decB.rs2),
        .value1A(value1A),
        .value2A(value2A),
        .value1B(value1B),
        .value2B(value2B),
        .writeA(writeA),
        .writeB(writeB)
    );

    assign hazard = conflicts(decA, decB);
    assign issueA = heldValid && !aDone;
    assign issueB = heldValid && (aDone || !hazard);
    assign take = issueB;

    // ----------------------------------------
    // split tracking and issue latch

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            aDone <= 1'b0;
        end else if (issueA && !issueB) begin
            aDone <= 1'b1;
        end else if (take) begin
            aDone <= 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issuedA <= '0;
            issuedB <= '0;
        end else begin
            issuedA <= '{slot: decA, src1Value: value1A, src2Value: value2A, valid: issueA};
            issuedB <= '{slot: decB, src1Value: value1B, src2Value: value2B, valid: issueB};
        end
    end

    // a lone slot A is followed by its slot B alone
    splitSlotFollows: assert property (
        @(posedge clock) disable iff (reset)
        (issuedA.valid && !issuedB.valid) |=> (issuedB.valid && !issuedA.valid)
    );

endmodule

`default_nettype wire

//--- design/slotAlu.sv
`timescale 1ns/1ps
`default_nettype none

module slotAlu (
    input  dualIssuePkg::aluOp_e op,
    input  dualIssuePkg::word_t  left,
    input  dualIssuePkg::word_t  right,
    output dualIssuePkg::word_t  result
);
    import dualIssuePkg::*;

    logic [4:0] shamt;

    assign shamt = right[4:0];

    always_comb begin
        case (op)
            aluAdd:  result = left + right;
            aluSub:  result = left - right;
            aluAnd:  result = left & right;
            aluOr:   result = left | right;
            aluXor:  result = left ^ right;
            aluSll:  result = left << shamt;
            aluSrl:  result = left >> shamt;
            aluSra:  result = word_t'($signed(left) >>> shamt);
            aluSlt:  result = word_t'($signed(left) < $signed(right));
            aluSltu: result = word_t'(left < right);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  dualIssuePkg::issued_t issuedA,
    input  dualIssuePkg::issued_t issuedB,
    input  dualIssuePkg::retire_t latchedA,
    input  dualIssuePkg::retire_t latchedB,
    output dualIssuePkg::retire_t resultA,
    output dualIssuePkg::retire_t resultB
);
    import dualIssuePkg::*;

    word_t leftA, rightA, leftB, rightB;
    word_t aluOutA, aluOutB;

    // newest value for a source register, slot B record is younger
    function automatic word_t forward(regIndex_t source, word_t issuedValue,
                                      retire_t olderA, retire_t olderB);
        word_t value;
        value = issuedValue;
        if ((source != '0) && olderA.valid && (olderA.rd == source)) value = olderA.value;
        if ((source != '0) && olderB.valid && (olderB.rd == source)) value = olderB.value;
        return value;
    endfunction

    always_comb begin
        leftA = forward(issuedA.slot.rs1, issuedA.src1Value, latchedA, latchedB);
        leftB = forward(issuedB.slot.rs1, issuedB.src1Value, latchedA, latchedB);
        rightA = issuedA.slot.usesImm ? issuedA.slot.imm
               : forward(issuedA.slot.rs2, issuedA.src2Value, latchedA, latchedB);
        rightB = issuedB.slot.usesImm ? issuedB.slot.imm
               : forward(issuedB.slot.rs2, issuedB.src2Value, latchedA, latchedB);
    end

    slotAlu aluA (.op(issuedA.slot.op), .left(leftA), .right(rightA), .result(aluOutA));
    slotAlu aluB (.op(issuedB.slot.op), .left(leftB), .right(rightB), .result(aluOutB));

    // only valid writing slots make a record
    assign resultA = '{
        valid: issuedA.valid && issuedA.slot.writes,
        rd: issuedA.slot.rd,
        value: aluOutA
    };
    assign resultB = '{
        valid: issuedB.valid && issuedB.slot.writes,
        rd: issuedB.slot.rd,
        value: aluOutB
    };

endmodule

`default_nettype wire

//--- design/retireStage.sv
`timescale 1ns/1ps
`default_nettype none

module retireStage (
    input  logic                  clock,
    input  logic                  reset,
    input  dualIssuePkg::retire_t resultA,
    input  dualIssuePkg::retire_t resultB,
    output dualIssuePkg::retire_t latchedA,
    output dualIssuePkg::retire_t latchedB,
    output dualIssuePkg::word_t   retiredCount
);
    import dualIssuePkg::*;

    logic [1:0] retiring; // 0, 1 or 2 per cycle

    assign retiring = {1'b0, resultA.valid} + {1'b0, resultB.valid};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            latchedA <= '0;
            latchedB <= '0;
            retiredCount <= '0;
        end else begin
            latchedA <= resultA;
            latchedB <= resultB;
            retiredCount <= retiredCount + word_t'(retiring);
        end
    end

    // decoder filters x0, nothing downstream may write it
    noZeroWrite: assert property (
        @(posedge clock) disable iff (reset)
        (latchedA.valid |-> latchedA.rd != '0) and (latchedB.valid |-> latchedB.rd != '0)
    );

endmodule

`default_nettype wire

//--- design/dualIssueCore.sv
`timescale 1ns/1ps
`default_nettype none

module dualIssueCore (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  packetReq,
    input  dualIssuePkg::packet_t packet,
    output logic                  packetAck,
    output dualIssuePkg::retire_t retireA,
    output dualIssuePkg::retire_t retireB,
    output dualIssuePkg::word_t   retiredCount
);
    import dualIssuePkg::*;

    packet_t held;
    logic heldValid;
    logic take;
    issued_t issuedA, issuedB;
    retire_t resultA, resultB;

    packetIntake intake (
        .clock(clock),
        .reset(reset),
        .packetReq(packetReq),
        .packet(packet),
        .packetAck(packetAck),
        .held(held),
        .heldValid(heldValid),
        .take(take)
    );

    // retire records double as writeback and forwarding sources
    issueStage issue (
        .clock(clock),
        .reset(reset),
        .held(held),
        .heldValid(heldValid),
        .take(take),
        .writeA(retireA),
        .writeB(retireB),
        .issuedA(issuedA),
        .issuedB(issuedB)
    );

    executeStage execute (
        .issuedA(issuedA),
        .issuedB(issuedB),
        .latchedA(retireA),
        .latchedB(retireB),
        .resultA(resultA),
        .resultB(resultB)
    );

    retireStage retire (
        .clock(clock),
        .reset(reset),
        .resultA(resultA),
        .resultB(resultB),
        .latchedA(retireA),
        .latchedB(retireB),
        .retiredCount(retiredCount)
    );

endmodule

`default_nettype wire

//--- bench/benchModel.svh
`ifndef BENCH_MODEL_SVH
`define BENCH_MODEL_SVH

// ----------------------------------------
// instruction encoders

function automatic word_t encodeReg(logic [6:0] funct7, logic [2:0] funct3,
                                    regIndex_t rd, regIndex_t rs1, regIndex_t rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic word_t encodeImm(logic [2:0] funct3, regIndex_t rd, regIndex_t rs1,
                                    logic [11:0] imm);
    return {imm, rs1, funct3, rd, 7'b0010011};
endfunction

function automatic word_t encodeNop();
    return encodeImm(3'd0, 5'd0, 5'd0, 12'd0); // addi x0, x0, 0
endfunction

// ----------------------------------------
// galois lfsr, one step per bit

logic [15:0] lfsrState = 16'd19105;

function automatic logic nextBit();
    logic out;
    out = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (out) lfsrState = lfsrState ^ 16'hB400;
    return out;
endfunction

function automatic word_t randomBits(int width);
    word_t value;
    value = '0;
    for (int i = 0; i < width; i++) begin
        value = {value[30:0], nextBit()};
    end
    return value;
endfunction

// ----------------------------------------
// architectural register model

word_t modelRegs [0:31];

function automatic retire_t modelStep(word_t instruction);
    retire_t rec;
    word_t left;
    word_t right;
    word_t value;
    logic signed [31:0] signedLeft;
    logic isReg;
    logic isImm;
    isReg = (instruction[6:0] == 7'b0110011);
    isImm = (instruction[6:0] == 7'b0010011);
    left = modelRegs[instruction[19:15]];
    signedLeft = left;
    if (isImm) right = {{20{instruction[31]}}, instruction[31:20]};
    else right = modelRegs[instruction[24:20]];
    case (instruction[14:12])
        3'd0: value = (isReg && instruction[30]) ? left - right : left + right;
        3'd1: value = left << right[4:0];
        3'd2: value = ($signed(left) < $signed(right)) ? 32'd1 : 32'd0;
        3'd3: value = (left < right) ? 32'd1 : 32'd0;
        3'd4: value = left ^ right;
        3'd5: begin
            if (instruction[30]) value = signedLeft >>> right[4:0]; // arithmetic
            else value = left >> right[4:0];
        end
        3'd6: value = left | right;
        default: value = left & right;
    endcase
    rec.valid = (isReg || isImm) && (instruction[11:7] != 5'd0);
    rec.rd = instruction[11:7];
    rec.value = value;
    if (rec.valid) modelRegs[rec.rd] = value;
    return rec;
endfunction

`endif

//--- bench/coreBench.sv
`timescale 1ns/1ps
`default_nettype none

module coreBench;
    import dualIssuePkg::*;

    logic clock;
    logic reset;
    logic packetReq;
    packet_t packet;
    logic packetAck;
    retire_t retireA;
    retire_t retireB;
    word_t retiredCount;

    retire_t seenQueue [$];
    int seenCycle [$]; // cycle of each record seen
    retire_t expectQueue [$];
    word_t expectCount = '0;
    int cycleCount = 0;
    int packetsSent = 0;
    int ackCycle = 0;
    int errorCount = 0;
    int checksRun = 0;

    `include "benchModel.svh"

    dualIssueCore dualIssueCore_inst (
        .clock(clock),
        .reset(reset),
        .packetReq(packetReq),
        .packet(packet),
        .packetAck(packetAck),
        .retireA(retireA),
        .retireB(retireB),
        .retiredCount(retiredCount)
    );

    always #50 clock = ~clock;

    // watchdog
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > 40 * packetsSent + 200) begin
            $display("run stopped after %0d cycles, the core stopped responding", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // retire monitor, slot A first
    always @(negedge clock) begin
        if (!reset) begin
            if (retireA.valid) begin
                seenQueue.push_back(retireA);
                seenCycle.push_back(cycleCount);
            end
            if (retireB.valid) begin
                seenQueue.push_back(retireB);
                seenCycle.push_back(cycleCount);
            end
        end
    end

    // ----------------------------------------
    // compare tasks

    task automatic checkRetire(string name, retire_t actual, retire_t expected);
        checksRun++;
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t: %s is valid=%0b rd=x%0d value=%h,",
                     $time, name, actual.valid, actual.rd, actual.value,
                     " expected valid=%0b rd=x%0d value=%h",
                     expected.valid, expected.rd, expected.value);
        end
    endtask

    task automatic checkCount(string name, word_t actual, word_t expected);
        checksRun++;
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkFlag(string name, logic actual, logic expected);
        checksRun++;
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic reportFailure(string what);
        errorCount++;
        $display("at %0t: %s", $time, what);
    endtask

    // ----------------------------------------
    // stimulus

    task automatic sendPacket(word_t slotA, word_t slotB);
        @(posedge clock);
        packetReq <= 1'b1;
        packet <= '{slotA: slotA, slotB: slotB};
        packetsSent++;
        @(negedge clock);
        while (!packetAck) @(negedge clock);
        ackCycle = cycleCount;
        @(posedge clock);
        packetReq <= 1'b0;
        @(negedge clock);
        while (packetAck) @(negedge clock);
    endtask

    task automatic predictRetire(word_t instruction);
        retire_t rec;
        rec = modelStep(instruction);
        if (rec.valid) begin
            expectQueue.push_back(rec);
            expectCount++;
        end
    endtask

    task automatic runPacket(word_t slotA, word_t slotB);
        predictRetire(slotA); // program order
        predictRetire(slotB);
        sendPacket(slotA, slotB);
    endtask

    task automatic drainRetires();
        while (seenQueue.size() < expectQueue.size()) @(negedge clock);
        repeat (3) @(negedge clock); // room for stray records
        if (seenQueue.size() != expectQueue.size())
            reportFailure($sformatf("%0d retire records seen where %0d were expected",
                                    seenQueue.size(), expectQueue.size()));
        for (int i = 0; i < seenQueue.size() && i < expectQueue.size(); i++) begin
            checkRetire($sformatf("retire record %0d", i), seenQueue[i], expectQueue[i]);
        end
        checkCount("retiredCount", retiredCount, expectCount);
        seenQueue.delete();
        expectQueue.delete();
    endtask

    task automatic loadRandom(regIndex_t r);
        runPacket(encodeImm(3'd0, r, 5'd0, 12'(randomBits(12))),
                  encodeImm(3'd1, r, r, {7'h00, 5'(randomBits(5))}));
        runPacket(encodeImm(3'd4, r, r, 12'(randomBits(12))), encodeNop());
    endtask

    // ----------------------------------------
    // tests

    task automatic testReset();
        checkFlag("packetAck", packetAck, 1'b0);
        checkRetire("retireA", retireA, '0);
        checkRetire("retireB", retireB, '0);
        checkCount("retiredCount", retiredCount, '0);
    endtask

    task automatic testIndependentAddi();
        runPacket(encodeImm(3'd0, 5'd1, 5'd0, 12'd100), encodeImm(3'd0, 5'd2, 5'd0, -12'sd37));
        drainRetires();
    endtask

    task automatic testAllOperations();
        logic [29:0] functs;
        logic [9:0] alt; // sub and sra
        logic [2:0] funct3;
        logic [11:0] imm;
        functs = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
        alt = 10'b0010000010;
        for (int i = 0; i < 10; i++) begin
            loadRandom(5'd1);
            loadRandom(5'd2);
            funct3 = functs[3*i +: 3];
            if (funct3 == 3'd1 || funct3 == 3'd5)
                imm = {alt[i] ? 7'h20 : 7'h00, 5'(randomBits(5))};
            else
                imm = 12'(randomBits(12));
            runPacket(encodeReg(alt[i] ? 7'h20 : 7'h00, funct3, 5'd10, 5'd1, 5'd2),
                      encodeImm(funct3, 5'd11, 5'd2, imm));
        end
        // -1 against 1, signed and unsigned
        runPacket(encodeImm(3'd0, 5'd1, 5'd0, 12'hFFF), encodeImm(3'd0, 5'd2, 5'd0, 12'd1));
        runPacket(encodeReg(7'h00, 3'd2, 5'd12, 5'd1, 5'd2),
                  encodeReg(7'h00, 3'd3, 5'd13, 5'd1, 5'd2));
        runPacket(encodeReg(7'h20, 3'd5, 5'd14, 5'd1, 5'd2),
                  encodeReg(7'h00, 3'd5, 5'd15, 5'd1, 5'd2));
        drainRetires();
    endtask

    task automatic testForwardChain();
        runPacket(encodeImm(3'd0, 5'd20, 5'd0, 12'd5), encodeImm(3'd0, 5'd21, 5'd0, 12'd7));
        for (int i = 0; i < 6; i++) begin
            runPacket(encodeReg(7'h00, 3'd0, 5'd22, 5'd20, 5'd21),
                      encodeReg(7'h20, 3'd0, 5'd23, 5'd21, 5'd20));
            runPacket(encodeReg(7'h00, 3'd0, 5'd20, 5'd22, 5'd23),
                      encodeReg(7'h00, 3'd4, 5'd21, 5'd22, 5'd23));
        end
        drainRetires();
    endtask

    task automatic testSplit();
        int base;
        int nextAck;
        base = seenCycle.size();
        // slot B reads slot A's rd
        runPacket(encodeImm(3'd0, 5'd5, 5'd0, 12'd11), encodeReg(7'h00, 3'd0, 5'd6, 5'd5, 5'd5));
        runPacket(encodeImm(3'd0, 5'd16, 5'd0, 12'd1), encodeImm(3'd0, 5'd17, 5'd0, 12'd2));
        nextAck = ackCycle;
        drainRetires();
        if (seenCycle[base] == seenCycle[base + 1])
            reportFailure("split packet retired both slots in the same cycle");
        // slot B left the packet register one cycle before it retired
        if (nextAck < seenCycle[base + 1])
            reportFailure("packetAck rose again before the split packet was consumed");
        // both slots write x7
        base = seenCycle.size();
        runPacket(encodeImm(3'd0, 5'd7, 5'd0, 12'd3), encodeImm(3'd0, 5'd7, 5'd0, 12'd9));
        drainRetires();
        if (seenCycle[base] == seenCycle[base + 1])
            reportFailure("packet writing one register twice retired in a single cycle");
        runPacket(encodeReg(7'h00, 3'd0, 5'd8, 5'd7, 5'd0), encodeNop());
        drainRetires();
    endtask

    task automatic testNoWrite();
        runPacket(encodeImm(3'd0, 5'd0, 5'd1, 12'd123), {20'hABCDE, 5'd9, 7'b0110111});
        drainRetires();
        runPacket(encodeReg(7'h00, 3'd0, 5'd24, 5'd0, 5'd9), encodeImm(3'd0, 5'd25, 5'd0, 12'd5));
        drainRetires();
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        packetReq = 1'b0;
        packet = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        testReset();
        testIndependentAddi();
        testAllOperations();
        testForwardChain();
        testSplit();
        testNoWrite();

        $display("%0d checks run, %0d errors", checksRun, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+bench
design/dualIssuePkg.sv
design/packetIntake.sv
design/slotDecoder.sv
design/registerFile.sv
design/issueStage.sv
design/slotAlu.sv
design/executeStage.sv
design/retireStage.sv
design/dualIssueCore.sv
bench/coreBench.sv
